// File: hdl/dbg_pkg.sv
package dbg_pkg;

    // command opcodes as sent by the host in the first byte of a command.
    typedef enum logic [7:0] {
        cmd_nop           = 8'h00,
        cmd_echo          = 8'h01,
        cmd_toggle_led    = 8'h02,
        cmd_enable_clock  = 8'h03,
        cmd_disable_clock = 8'h04,
        cmd_step_clock    = 8'h05,
        cmd_get_pc        = 8'h06,
        cmd_get_reg       = 8'h07
    } dbg_cmd_t;

    // controller states, one per kind of byte the controller expects next.
    typedef enum logic [1:0] {
        st_idle,
        st_echo,
        st_read_reg,
        st_replying
    } dbg_state_t;

    // reply to every simple command and to unknown opcodes.
    localparam logic [7:0] reply_ack = 8'h00;

    // length byte ahead of a word reply, also the number of bytes that follow.
    localparam logic [7:0] reply_len = 8'h08;

endpackage

// File: hdl/core_pkg.sv
package core_pkg;

    // register index width, 32 registers.
    localparam int reg_idx_w = 5;

    localparam int num_regs = 2 ** reg_idx_w;

    typedef enum logic [1:0] {
        op_addi,
        op_add,
        op_jump
    } core_op_t;

    // one ROM entry.
    // addi: rd = rs1 + imm.
    // add:  rd = rs1 + rs2.
    // jump: pc = imm.
    typedef struct packed {
        core_op_t             op;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [7:0]           imm;
    } core_insn_t;

endpackage

// File: hdl/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss,
    input  logic [7:0] send_data,
    output logic       miso,
    output logic [7:0] recv_data,
    output logic       recv_ready
);

    // two-flop synchronizers, plus one more stage on sclk for edge detection.
    logic sclk_meta;
    logic sclk_s;
    logic sclk_q;
    logic mosi_meta;
    logic mosi_s;
    logic ss_meta;
    logic ss_s;

    logic sclk_rise;
    logic sclk_fall;

    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [6:0] tx_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_meta <= 1'b0;
            sclk_s    <= 1'b0;
            sclk_q    <= 1'b0;
            mosi_meta <= 1'b0;
            mosi_s    <= 1'b0;
            ss_meta   <= 1'b1;
            ss_s      <= 1'b1;
        end else begin
            sclk_meta <= sclk;
            sclk_s    <= sclk_meta;
            sclk_q    <= sclk_s;
            mosi_meta <= mosi;
            mosi_s    <= mosi_meta;
            ss_meta   <= ss;
            ss_s      <= ss_meta;
        end
    end

    assign sclk_rise = sclk_s & ~sclk_q;
    assign sclk_fall = ~sclk_s & sclk_q;

    // bit counter, strobe and miso.
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            recv_ready <= 1'b0;
            miso       <= 1'b0;
        end else begin
            recv_ready <= 1'b0;
            if (ss_s) begin
                bit_cnt <= '0;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        recv_ready <= 1'b1;
                    end
                end
                // a falling edge with the count at zero starts the next byte.
                if (sclk_fall) begin
                    if (bit_cnt == 3'd0) begin
                        miso <= send_data[7];
                    end else begin
                        miso <= tx_shift[6];
                    end
                end
            end
        end
    end

    // receive and transmit data paths.
    always_ff @(posedge clk) begin
        if (!ss_s && sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_s};
            if (bit_cnt == 3'd7) begin
                recv_data <= {rx_shift, mosi_s};
            end
        end
        if (!ss_s && sclk_fall) begin
            if (bit_cnt == 3'd0) begin
                tx_shift <= send_data[6:0];
            end else begin
                tx_shift <= {tx_shift[5:0], 1'b0};
            end
        end
    end

endmodule

// File: hdl/dbg_controller.sv
`timescale 1ns/1ps

module dbg_controller
    import dbg_pkg::*;
    import core_pkg::*;
#(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           recv_data,
    input  logic                 recv_ready,
    input  logic [xlen-1:0]      reg_pc,
    input  logic [xlen-1:0]      reg_read_data,
    output logic [7:0]           send_data,
    output logic                 led,
    output logic                 core_tick,
    output logic [reg_idx_w-1:0] reg_read_sel
);

    dbg_state_t state;

    logic [63:0] send_buf;
    logic [3:0]  send_cnt;

    // core clock control.
    logic run_en;
    logic step_tgl;
    logic step_tgl_q;

    // the register index byte drives the core read port directly.
    assign reg_read_sel = recv_data[reg_idx_w-1:0];

    // one tick per toggle change, or every cycle while running.
    assign core_tick = run_en | (step_tgl != step_tgl_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            send_data  <= reply_ack;
            send_cnt   <= '0;
            led        <= 1'b0;
            run_en     <= 1'b0;
            step_tgl   <= 1'b0;
            step_tgl_q <= 1'b0;
        end else begin
            step_tgl_q <= step_tgl;
            if (recv_ready) begin
                case (state)
                    st_idle: begin
                        send_data <= reply_ack;
                        case (dbg_cmd_t'(recv_data))
                            cmd_nop: begin
                            end
                            cmd_echo: begin
                                send_data <= cmd_echo;
                                state     <= st_echo;
                            end
                            cmd_toggle_led: begin
                                led <= ~led;
                            end
                            cmd_enable_clock: begin
                                run_en <= 1'b1;
                            end
                            cmd_disable_clock: begin
                                run_en <= 1'b0;
                            end
                            cmd_step_clock: begin
                                step_tgl <= ~step_tgl;
                            end
                            cmd_get_pc: begin
                                send_data <= reply_len;
                                send_cnt  <= reply_len[3:0];
                                state     <= st_replying;
                            end
                            cmd_get_reg: begin
                                state <= st_read_reg;
                            end
                            default: begin
                            end
                        endcase
                    end
                    st_echo: begin
                        send_data <= recv_data;
                        state     <= st_idle;
                    end
                    st_read_reg: begin
                        send_data <= reply_len;
                        send_cnt  <= reply_len[3:0];
                        state     <= st_replying;
                    end
                    st_replying: begin
                        send_data <= send_buf[63:56];
                        send_cnt  <= send_cnt - 4'd1;
                        if (send_cnt == 4'd1) begin
                            state <= st_idle;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // word reply buffer, MSB byte first.
    always_ff @(posedge clk) begin
        if (recv_ready) begin
            if (state == st_idle && recv_data == cmd_get_pc) begin
                send_buf <= 64'(reg_pc);
            end else if (state == st_read_reg) begin
                send_buf <= 64'(reg_read_data);
            end else if (state == st_replying) begin
                send_buf <= {send_buf[55:0], 8'h00};
            end
        end
    end

endmodule

// File: hdl/mini_core.sv
`timescale 1ns/1ps

module mini_core
    import core_pkg::*;
#(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 core_tick,
    input  logic [reg_idx_w-1:0] reg_read_sel,
    output logic [xlen-1:0]      reg_pc,
    output logic [xlen-1:0]      reg_read_data
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] regs [num_regs];

    core_insn_t      insn;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] result;

    // fixed program, one entry per word.
    function automatic core_insn_t rom_fetch(input logic [1:0] idx);
        core_insn_t entry;
        entry = '{op_jump, '0, '0, '0, 8'd0};
        case (idx)
            // x1 = x1 + 1.
            2'd0: entry = '{op_addi, 5'd1, 5'd1, 5'd0, 8'd1};
            // x2 = x2 + x1.
            2'd1: entry = '{op_add, 5'd2, 5'd2, 5'd1, 8'd0};
            // x3 = x3 + 3.
            2'd2: entry = '{op_addi, 5'd3, 5'd3, 5'd0, 8'd3};
            // back to the start.
            default: entry = '{op_jump, 5'd0, 5'd0, 5'd0, 8'd0};
        endcase
        return entry;
    endfunction

    assign insn = rom_fetch(pc[3:2]);

    assign rs1_val = (insn.rs1 == '0) ? '0 : regs[insn.rs1];
    assign rs2_val = (insn.rs2 == '0) ? '0 : regs[insn.rs2];

    always_comb begin
        case (insn.op)
            op_addi: result = rs1_val + xlen'(insn.imm);
            op_add:  result = rs1_val + rs2_val;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (core_tick) begin
            if (insn.op == op_jump) begin
                pc <= xlen'(insn.imm);
            end else begin
                pc <= pc + xlen'(4);
                // x0 stays zero.
                if (insn.rd != '0) begin
                    regs[insn.rd] <= result;
                end
            end
        end
    end

    // debug read ports.
    assign reg_pc        = pc;
    assign reg_read_data = (reg_read_sel == '0) ? '0 : regs[reg_read_sel];

endmodule

// File: hdl/dbg_top.sv
`timescale 1ns/1ps

module dbg_top
    import core_pkg::*;
#(
    parameter int xlen = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic ss,
    output logic miso,
    output logic led
);

    logic [7:0]           send_data;
    logic [7:0]           recv_data;
    logic                 recv_ready;
    logic                 core_tick;
    logic [reg_idx_w-1:0] reg_read_sel;
    logic [xlen-1:0]      reg_pc;
    logic [xlen-1:0]      reg_read_data;

    spi_slave spi_i (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss         (ss),
        .send_data  (send_data),
        .miso       (miso),
        .recv_data  (recv_data),
        .recv_ready (recv_ready)
    );

    dbg_controller #(
        .xlen (xlen)
    ) ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .recv_data     (recv_data),
        .recv_ready    (recv_ready),
        .reg_pc        (reg_pc),
        .reg_read_data (reg_read_data),
        .send_data     (send_data),
        .led           (led),
        .core_tick     (core_tick),
        .reg_read_sel  (reg_read_sel)
    );

    mini_core #(
        .xlen (xlen)
    ) core_i (
        .clk           (clk),
        .rst           (rst),
        .core_tick     (core_tick),
        .reg_read_sel  (reg_read_sel),
        .reg_pc        (reg_pc),
        .reg_read_data (reg_read_data)
    );

endmodule

// File: verification/tb_dbg_top.sv
`timescale 1ns/1ps

module tb_dbg_top;

    // clk cycles per SPI half-period, and the longest idle gap between bytes.
    localparam int half_period = 16;
    localparam int max_gap     = 20;
    localparam string case_file = "verification/dbg_cases.txt";

    logic clk;
    logic rst;
    logic sclk;
    logic mosi;
    logic ss;
    logic miso;
    logic led;

    int cycle_cnt = 0;
    int cycle_limit = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    string      name_q[$];
    logic [7:0] tx_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] mask_q[$];
    logic       led_q[$];

    dbg_top #(
        .xlen (32)
    ) dut_i (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .ss   (ss),
        .miso (miso),
        .led  (led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the cases did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // one line per byte, lines starting with # are skipped.
    task automatic load_cases();
        int         fd;
        int         n;
        string      line;
        string      name;
        logic [7:0] tx;
        logic [7:0] exp_val;
        logic [7:0] mask;
        logic       led_exp;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", case_file);
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %h %h %h %h", name, tx, exp_val, mask, led_exp);
                if (n == 5 && line[0] != "#") begin
                    name_q.push_back(name);
                    tx_q.push_back(tx);
                    exp_q.push_back(exp_val);
                    mask_q.push_back(mask);
                    led_q.push_back(led_exp);
                end
            end
            $fclose(fd);
        end
    endtask

    // SPI mode 0 master, miso is sampled just before each rising sclk.
    task automatic spi_transfer(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            mosi = tx[i];
            repeat (half_period) @(negedge clk);
            rx[i] = miso;
            sclk = 1'b1;
            repeat (half_period) @(negedge clk);
            sclk = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s passed", name);
            pass_cnt++;
        end else begin
            $display("test %s failed with %0d errors", name, errs);
            fail_cnt++;
        end
    endtask

    initial begin
        logic [7:0] rx;
        int         gap;
        int         test_errs;
        rst  = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        ss   = 1'b1;
        test_errs = 0;
        void'($urandom(32'h9530));
        load_cases();
        cycle_limit = tx_q.size() * (8 * 2 * half_period + max_gap) + 1000;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        // one transaction over the whole case file.
        ss = 1'b0;
        repeat (half_period) @(negedge clk);
        for (int k = 0; k < tx_q.size(); k++) begin
            if (k > 0 && name_q[k] != name_q[k-1]) begin
                report_test(name_q[k-1], test_errs);
                test_errs = 0;
            end
            spi_transfer(tx_q[k], rx);
            if ((rx & mask_q[k]) !== (exp_q[k] & mask_q[k])) begin
                $display("MISMATCH %s byte %0d: expected %h, actual %h, mask %h",
                         name_q[k], k, exp_q[k], rx, mask_q[k]);
                test_errs++;
            end
            if (led !== led_q[k]) begin
                $display("MISMATCH %s led after byte %0d: expected %b, actual %b",
                         name_q[k], k, led_q[k], led);
                test_errs++;
            end
            gap = $urandom % (max_gap + 1);
            repeat (gap) @(negedge clk);
        end
        if (tx_q.size() > 0) begin
            report_test(name_q[tx_q.size()-1], test_errs);
        end
        ss = 1'b1;
        repeat (half_period) @(negedge clk);
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && tx_q.size() > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verification/dbg_cases.txt
# test, byte sent, reply seen while it is sent (reply to the byte before),
# mask for that reply, led after the byte. all hex.
echo    01 00 00 0
echo    ab 01 ff 0
led     02 ab ff 1
led     02 00 ff 0
# five steps from reset, pc ends on 4.
step    05 00 ff 0
step    05 00 ff 0
step    05 00 ff 0
step    05 00 ff 0
step    05 00 ff 0
get_pc  06 00 ff 0
get_pc  00 08 ff 0
get_pc  00 00 ff 0
get_pc  00 00 ff 0
get_pc  00 00 ff 0
get_pc  00 00 ff 0
get_pc  00 00 ff 0
get_pc  00 00 ff 0
get_pc  00 00 ff 0
# x1 = 2, x2 = 1, x3 = 3, x0 = 0.
reg_x1  07 04 ff 0
reg_x1  01 00 ff 0
reg_x1  00 08 ff 0
reg_x1  00 00 ff 0
reg_x1  00 00 ff 0
reg_x1  00 00 ff 0
reg_x1  00 00 ff 0
reg_x1  00 00 ff 0
reg_x1  00 00 ff 0
reg_x1  00 00 ff 0
reg_x2  07 02 ff 0
reg_x2  02 00 ff 0
reg_x2  00 08 ff 0
reg_x2  00 00 ff 0
reg_x2  00 00 ff 0
reg_x2  00 00 ff 0
reg_x2  00 00 ff 0
reg_x2  00 00 ff 0
reg_x2  00 00 ff 0
reg_x2  00 00 ff 0
reg_x3  07 01 ff 0
reg_x3  03 00 ff 0
reg_x3  00 08 ff 0
reg_x3  00 00 ff 0
reg_x3  00 00 ff 0
reg_x3  00 00 ff 0
reg_x3  00 00 ff 0
reg_x3  00 00 ff 0
reg_x3  00 00 ff 0
reg_x3  00 00 ff 0
reg_x0  07 03 ff 0
reg_x0  00 00 ff 0
reg_x0  00 08 ff 0
reg_x0  00 00 ff 0
reg_x0  00 00 ff 0
reg_x0  00 00 ff 0
reg_x0  00 00 ff 0
reg_x0  00 00 ff 0
reg_x0  00 00 ff 0
reg_x0  00 00 ff 0
# enable, disable, then pc is a multiple of 4 below 16.
run     03 00 ff 0
run     04 00 ff 0
run     06 00 ff 0
run     00 08 ff 0
run     00 00 ff 0
run     00 00 ff 0
run     00 00 ff 0
run     00 00 ff 0
run     00 00 ff 0
run     00 00 ff 0
run     00 00 ff 0
# 3c is not an opcode, the first line here also takes the low pc byte.
unknown 3c 00 f3 0
unknown 01 00 ff 0
unknown 5a 01 ff 0
unknown 00 5a ff 0

// File: tb.f
hdl/dbg_pkg.sv
hdl/core_pkg.sv
hdl/spi_slave.sv
hdl/dbg_controller.sv
hdl/mini_core.sv
hdl/dbg_top.sv
verification/tb_dbg_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dbg_top
OBJ_DIR   ?= obj_dir
FLAGS     ?= -j 0

SOURCES := $(shell cat tb.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): tb.f $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
